// File: common/line_conv_pkg.sv
package line_conv_pkg;

    //////////////////////////////
    // Data widths
    //////////////////////////////

    // One channel value of a pixel or a weight
    localparam int BIT_WIDTH = 8;

    // Partial sum width, wraps on overflow
    localparam int PSUM_WIDTH = 16;

    //////////////////////////////
    // Default geometry
    //////////////////////////////

    localparam int DEF_NUM_CHANNEL = 3;
    localparam int DEF_NUM_KERNEL  = 4;
    localparam int DEF_KERNEL_SIZE = 3;

    //////////////////////////////
    // Types
    //////////////////////////////

    typedef logic signed [BIT_WIDTH-1:0] chan_t;
    typedef logic signed [PSUM_WIDTH-1:0] psum_t;

    // Pixels per line
    typedef logic [11:0] line_len_t;

    // Lines per run
    typedef logic [7:0] line_cnt_t;

    // Line controller phases
    typedef enum logic [1:0] {
        IDLE,
        LOAD_WEIGHT,
        STREAM,
        FINISH
    } ctrl_state_t;

endpackage

// File: source/act_window.sv
`timescale 1ns/10ps

module act_window import line_conv_pkg::*; #(
    parameter int NUM_CHANNEL = DEF_NUM_CHANNEL,
    parameter int KERNEL_SIZE = DEF_KERNEL_SIZE
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      i_shift,
    input  logic                                      i_last,
    input  logic [NUM_CHANNEL*BIT_WIDTH-1:0]          i_pixel,
    output logic [KERNEL_SIZE*NUM_CHANNEL*BIT_WIDTH-1:0] o_win,
    output logic                                      o_win_vld,
    output logic                                      o_win_last
);

    localparam int PIX_W = NUM_CHANNEL * BIT_WIDTH;
    localparam int CNT_W = $clog2(KERNEL_SIZE + 1);

    // Slot 0 holds the oldest pixel
    logic [PIX_W-1:0] win_q [KERNEL_SIZE];
    logic [CNT_W-1:0] fill_q;
    logic             fills;

    always_ff @(posedge clk) begin
        if (i_shift) begin
            for (int t = 0; t < KERNEL_SIZE - 1; t++) begin
                win_q[t] <= win_q[t+1];
            end
            win_q[KERNEL_SIZE-1] <= i_pixel;
        end
    end

    // Window complete once this pixel lands
    assign fills = (fill_q >= CNT_W'(KERNEL_SIZE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_q     <= '0;
            o_win_vld  <= 1'b0;
            o_win_last <= 1'b0;
        end else begin
            o_win_vld  <= i_shift && fills;
            o_win_last <= i_shift && i_last;
            if (i_shift) begin
                if (i_last) begin
                    // Next line starts from an empty window
                    fill_q <= '0;
                end else if (!fills) begin
                    fill_q <= fill_q + 1'b1;
                end
            end
        end
    end

    for (genvar t = 0; t < KERNEL_SIZE; t++) begin : g_win
        assign o_win[t*PIX_W +: PIX_W] = win_q[t];
    end

    a_last_with_shift: assert property (@(posedge clk) disable iff (rst) i_last |-> i_shift);

endmodule

// File: source/weight_store.sv
`timescale 1ns/10ps

module weight_store import line_conv_pkg::*; #(
    parameter int NUM_CHANNEL = DEF_NUM_CHANNEL,
    parameter int NUM_KERNEL  = DEF_NUM_KERNEL,
    parameter int KERNEL_SIZE = DEF_KERNEL_SIZE
) (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic                                                 i_clr,
    input  logic                                                 i_wr,
    input  logic [NUM_KERNEL*NUM_CHANNEL*BIT_WIDTH-1:0]          i_beat,
    output logic [KERNEL_SIZE*NUM_KERNEL*NUM_CHANNEL*BIT_WIDTH-1:0] o_taps,
    output logic                                                 o_full
);

    localparam int BEAT_W = NUM_KERNEL * NUM_CHANNEL * BIT_WIDTH;
    localparam int PTR_W  = (KERNEL_SIZE > 1) ? $clog2(KERNEL_SIZE) : 1;

    // One tap of every kernel per entry
    logic [BEAT_W-1:0] tap_q [KERNEL_SIZE];
    logic [PTR_W-1:0]  wr_ptr;
    logic              ptr_last;

    assign ptr_last = (wr_ptr == PTR_W'(KERNEL_SIZE - 1));

    always_ff @(posedge clk) begin
        if (i_wr) begin
            tap_q[wr_ptr] <= i_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_clr) begin
            wr_ptr <= '0;
            o_full <= 1'b0;
        end else if (i_wr) begin
            wr_ptr <= ptr_last ? '0 : wr_ptr + 1'b1;
            if (ptr_last) begin
                o_full <= 1'b1;
            end
        end
    end

    for (genvar t = 0; t < KERNEL_SIZE; t++) begin : g_tap
        assign o_taps[t*BEAT_W +: BEAT_W] = tap_q[t];
    end

    // Controller must stop requesting once the store is full
    a_no_write_full: assert property (@(posedge clk) disable iff (rst) o_full |-> !i_wr);

endmodule

// File: kcpe_array/kernel_channel_pe.sv
`timescale 1ns/10ps

module kernel_channel_pe import line_conv_pkg::*; #(
    parameter int NUM_CHANNEL = DEF_NUM_CHANNEL,
    parameter int KERNEL_SIZE = DEF_KERNEL_SIZE
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         i_vld,
    input  logic [KERNEL_SIZE*NUM_CHANNEL*BIT_WIDTH-1:0] i_win,
    input  logic [KERNEL_SIZE*NUM_CHANNEL*BIT_WIDTH-1:0] i_taps,
    output psum_t                                        o_psum,
    output logic                                         o_vld
);

    localparam int NUM_PROD = KERNEL_SIZE * NUM_CHANNEL;

    psum_t prod_q [NUM_PROD];
    logic  vld_q;
    psum_t sum;

    //////////////////////////////
    // Stage 1: products
    //////////////////////////////

    // Window and taps share the tap-major, channel-minor layout
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_PROD; i++) begin
            prod_q[i] <= chan_t'(i_win[i*BIT_WIDTH +: BIT_WIDTH])
                       * chan_t'(i_taps[i*BIT_WIDTH +: BIT_WIDTH]);
        end
    end

    //////////////////////////////
    // Stage 2: adder tree
    //////////////////////////////

    always_comb begin
        sum = '0;
        for (int i = 0; i < NUM_PROD; i++) begin
            sum = sum + prod_q[i];
        end
    end

    always_ff @(posedge clk) begin
        o_psum <= sum;
    end

    // Valid follows the data through both stages
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= 1'b0;
            o_vld <= 1'b0;
        end else begin
            vld_q <= i_vld;
            o_vld <= vld_q;
        end
    end

    a_vld_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(o_vld));

endmodule

// File: kcpe_array/kcpe_array.sv
`timescale 1ns/10ps

module kcpe_array import line_conv_pkg::*; #(
    parameter int NUM_CHANNEL = DEF_NUM_CHANNEL,
    parameter int NUM_KERNEL  = DEF_NUM_KERNEL,
    parameter int KERNEL_SIZE = DEF_KERNEL_SIZE
) (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic                                                    i_win_vld,
    input  logic                                                    i_win_last,
    input  logic [KERNEL_SIZE*NUM_CHANNEL*BIT_WIDTH-1:0]            i_win,
    input  logic [KERNEL_SIZE*NUM_KERNEL*NUM_CHANNEL*BIT_WIDTH-1:0] i_taps,
    output logic [NUM_KERNEL*PSUM_WIDTH-1:0]                        o_psum,
    output logic                                                    o_psum_vld,
    output logic                                                    o_psum_end
);

    localparam int KER_W = NUM_CHANNEL * BIT_WIDTH;
    localparam int WIN_W = KERNEL_SIZE * KER_W;

    logic [NUM_KERNEL-1:0] pe_vld;
    logic [1:0]            last_pipe;

    for (genvar k = 0; k < NUM_KERNEL; k++) begin : g_pe
        logic [WIN_W-1:0] kern_taps;

        // Store is tap-major; pick kernel k out of every tap
        for (genvar t = 0; t < KERNEL_SIZE; t++) begin : g_tap
            assign kern_taps[t*KER_W +: KER_W] = i_taps[(t*NUM_KERNEL + k)*KER_W +: KER_W];
        end

        kernel_channel_pe #(
            .NUM_CHANNEL (NUM_CHANNEL),
            .KERNEL_SIZE (KERNEL_SIZE)
        ) kernel_channel_pe_i (
            .clk    (clk),
            .rst    (rst),
            .i_vld  (i_win_vld),
            .i_win  (i_win),
            .i_taps (kern_taps),
            .o_psum (o_psum[k*PSUM_WIDTH +: PSUM_WIDTH]),
            .o_vld  (pe_vld[k])
        );
    end

    // End tag rides alongside the two PE stages
    always_ff @(posedge clk) begin
        if (rst) begin
            last_pipe <= '0;
        end else begin
            last_pipe <= {last_pipe[0], i_win_last};
        end
    end

    assign o_psum_vld = pe_vld[0];
    assign o_psum_end = last_pipe[1];

    a_pe_vld_agree: assert property (@(posedge clk) disable iff (rst)
        (&pe_vld) || !(|pe_vld));

endmodule

// File: source/line_ctrl.sv
`timescale 1ns/10ps

module line_ctrl import line_conv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      i_start,
    input  line_len_t i_line_len,
    input  line_cnt_t i_num_lines,
    input  logic      i_weight_vld,
    input  logic      i_data_vld,
    input  logic      i_full,
    input  logic      i_line_done,
    output logic      o_weight_req,
    output logic      o_data_req,
    output logic      o_wr,
    output logic      o_clr,
    output logic      o_shift,
    output logic      o_last,
    output logic      o_done
);

    ctrl_state_t state;
    line_len_t   line_len_q;
    line_cnt_t   num_lines_q;
    line_len_t   pix_cnt;
    line_cnt_t   in_line_cnt;
    line_cnt_t   out_line_cnt;
    logic        start_ok;
    logic        pix_last;
    logic        in_line_last;
    logic        out_line_last;

    //////////////////////////////
    // Accept strobes
    //////////////////////////////

    assign start_ok = i_start && (state == IDLE || state == FINISH);

    // Drop the request as soon as the store reports full
    assign o_weight_req = (state == LOAD_WEIGHT) && !i_full;
    assign o_data_req   = (state == STREAM);

    assign o_wr    = o_weight_req && i_weight_vld;
    assign o_clr   = start_ok;
    assign o_shift = o_data_req && i_data_vld;

    assign pix_last      = (pix_cnt == line_len_q - 1'b1);
    assign in_line_last  = (in_line_cnt == num_lines_q - 1'b1);
    assign out_line_last = (out_line_cnt == num_lines_q - 1'b1);

    assign o_last = o_shift && pix_last;

    //////////////////////////////
    // Phase FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            line_len_q  <= '0;
            num_lines_q <= '0;
        end else begin
            case (state)
                IDLE, FINISH: begin
                    if (start_ok) begin
                        state       <= LOAD_WEIGHT;
                        line_len_q  <= i_line_len;
                        num_lines_q <= i_num_lines;
                    end
                end
                LOAD_WEIGHT: begin
                    if (i_full) begin
                        state <= STREAM;
                    end
                end
                STREAM: begin
                    if (o_last && in_line_last) begin
                        state <= FINISH;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Input side position within a line and lines fed
    always_ff @(posedge clk) begin
        if (rst || start_ok) begin
            pix_cnt     <= '0;
            in_line_cnt <= '0;
        end else if (o_shift) begin
            pix_cnt <= pix_last ? '0 : pix_cnt + 1'b1;
            if (pix_last) begin
                in_line_cnt <= in_line_cnt + 1'b1;
            end
        end
    end

    // Output side lines finished, done once the last end marker shows up
    always_ff @(posedge clk) begin
        if (rst || start_ok) begin
            out_line_cnt <= '0;
            o_done       <= 1'b0;
        end else if (i_line_done) begin
            out_line_cnt <= out_line_cnt + 1'b1;
            if (state == FINISH && out_line_last) begin
                o_done <= 1'b1;
            end
        end
    end

    a_req_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(o_weight_req && o_data_req));

endmodule

// File: source/line_conv_engine.sv
`timescale 1ns/10ps

module line_conv_engine import line_conv_pkg::*; #(
    parameter int NUM_CHANNEL = DEF_NUM_CHANNEL,
    parameter int NUM_KERNEL  = DEF_NUM_KERNEL,
    parameter int KERNEL_SIZE = DEF_KERNEL_SIZE
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        i_start,
    input  line_len_t                                   i_line_len,
    input  line_cnt_t                                   i_num_lines,
    input  logic [NUM_KERNEL*NUM_CHANNEL*BIT_WIDTH-1:0] i_weight,
    input  logic                                        i_weight_vld,
    input  logic [NUM_CHANNEL*BIT_WIDTH-1:0]            i_data,
    input  logic                                        i_data_vld,
    output logic                                        o_weight_req,
    output logic                                        o_data_req,
    output logic [NUM_KERNEL*PSUM_WIDTH-1:0]            o_psum,
    output logic                                        o_psum_vld,
    output logic                                        o_psum_end,
    output logic                                        o_done
);

    localparam int WIN_W  = KERNEL_SIZE * NUM_CHANNEL * BIT_WIDTH;
    localparam int TAPS_W = KERNEL_SIZE * NUM_KERNEL * NUM_CHANNEL * BIT_WIDTH;

    logic              wr;
    logic              clr;
    logic              shift;
    logic              last;
    logic              full;
    logic [TAPS_W-1:0] taps;
    logic [WIN_W-1:0]  win;
    logic              win_vld;
    logic              win_last;

    line_ctrl line_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .i_start      (i_start),
        .i_line_len   (i_line_len),
        .i_num_lines  (i_num_lines),
        .i_weight_vld (i_weight_vld),
        .i_data_vld   (i_data_vld),
        .i_full       (full),
        .i_line_done  (o_psum_end),
        .o_weight_req (o_weight_req),
        .o_data_req   (o_data_req),
        .o_wr         (wr),
        .o_clr        (clr),
        .o_shift      (shift),
        .o_last       (last),
        .o_done       (o_done)
    );

    weight_store #(
        .NUM_CHANNEL (NUM_CHANNEL),
        .NUM_KERNEL  (NUM_KERNEL),
        .KERNEL_SIZE (KERNEL_SIZE)
    ) weight_store_i (
        .clk    (clk),
        .rst    (rst),
        .i_clr  (clr),
        .i_wr   (wr),
        .i_beat (i_weight),
        .o_taps (taps),
        .o_full (full)
    );

    act_window #(
        .NUM_CHANNEL (NUM_CHANNEL),
        .KERNEL_SIZE (KERNEL_SIZE)
    ) act_window_i (
        .clk        (clk),
        .rst        (rst),
        .i_shift    (shift),
        .i_last     (last),
        .i_pixel    (i_data),
        .o_win      (win),
        .o_win_vld  (win_vld),
        .o_win_last (win_last)
    );

    kcpe_array #(
        .NUM_CHANNEL (NUM_CHANNEL),
        .NUM_KERNEL  (NUM_KERNEL),
        .KERNEL_SIZE (KERNEL_SIZE)
    ) kcpe_array_i (
        .clk        (clk),
        .rst        (rst),
        .i_win_vld  (win_vld),
        .i_win_last (win_last),
        .i_win      (win),
        .i_taps     (taps),
        .o_psum     (o_psum),
        .o_psum_vld (o_psum_vld),
        .o_psum_end (o_psum_end)
    );

endmodule

// File: testbench/line_conv_engine_tb.sv
`timescale 1ns/10ps

module line_conv_engine_tb import line_conv_pkg::*;;

    localparam int NC        = DEF_NUM_CHANNEL;
    localparam int NK        = DEF_NUM_KERNEL;
    localparam int KS        = DEF_KERNEL_SIZE;
    localparam int MAX_LINES = 8;
    localparam int MAX_LEN   = 32;

    // Pixels of all four runs plus their weight beats
    localparam int TOTAL_WORK = 12 * 1 + 16 * 4 + 10 * 2 + 7 * 3 + 4 * KS;
    localparam int CYCLE_LIMIT = 4 * TOTAL_WORK + 200;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      i_start;
    line_len_t                 i_line_len;
    line_cnt_t                 i_num_lines;
    logic [NK*NC*BIT_WIDTH-1:0] i_weight;
    logic                      i_weight_vld;
    logic [NC*BIT_WIDTH-1:0]   i_data;
    logic                      i_data_vld;
    logic                      o_weight_req;
    logic                      o_data_req;
    logic [NK*PSUM_WIDTH-1:0]  o_psum;
    logic                      o_psum_vld;
    logic                      o_psum_end;
    logic                      o_done;

    // Local copies of weights and line pixels
    chan_t wt  [KS][NK][NC];
    chan_t pix [MAX_LINES][MAX_LEN][NC];

    int seed = 32'h91f5;
    int cfg_len;
    int cfg_lines;
    int exp_line;
    int exp_pos;
    int end_cycle;
    int cycle = 0;
    int err_value;
    int err_proto;
    bit run_active;

    line_conv_engine #(
        .NUM_CHANNEL (NC),
        .NUM_KERNEL  (NK),
        .KERNEL_SIZE (KS)
    ) line_conv_engine_i (
        .clk          (clk),
        .rst          (rst),
        .i_start      (i_start),
        .i_line_len   (i_line_len),
        .i_num_lines  (i_num_lines),
        .i_weight     (i_weight),
        .i_weight_vld (i_weight_vld),
        .i_data       (i_data),
        .i_data_vld   (i_data_vld),
        .o_weight_req (o_weight_req),
        .o_data_req   (o_data_req),
        .o_psum       (o_psum),
        .o_psum_vld   (o_psum_vld),
        .o_psum_end   (o_psum_end),
        .o_done       (o_done)
    );

    always #2 clk = ~clk;

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Tap 0 meets the oldest pixel of the window
    function automatic psum_t ref_sum(input int line, input int pos, input int k);
        int acc;
        acc = 0;
        for (int t = 0; t < KS; t++) begin
            for (int c = 0; c < NC; c++) begin
                acc = acc + int'(pix[line][pos+t][c]) * int'(wt[t][k][c]);
            end
        end
        return psum_t'(acc);
    endfunction

    // Mode 1 draws only the two extremes
    function automatic chan_t pick_value(input int mode);
        int r;
        r = $random(seed);
        if (mode == 1) begin
            return r[0] ? chan_t'(127) : chan_t'(-128);
        end
        return chan_t'(r);
    endfunction

    //////////////////////////////
    // Output checks
    //////////////////////////////

    always @(negedge clk) begin : compare_sums
        psum_t got;
        psum_t want;
        logic  last_pos;
        if (!rst) begin
            if (o_weight_req && o_data_req) begin
                $display("Error at %0t: weight and data requests high together", $time);
                err_proto++;
            end
            if (o_psum_end && !o_psum_vld) begin
                $display("Error at %0t: end marker without a valid sum", $time);
                err_proto++;
            end
            if (run_active && o_done && exp_line < cfg_lines) begin
                $display("Error at %0t: done raised before the last line ended", $time);
                err_proto++;
            end
            if (o_psum_vld) begin
                if (!run_active || exp_line >= cfg_lines) begin
                    $display("Error at %0t: sum appeared after the last line", $time);
                    err_proto++;
                end else begin
                    for (int k = 0; k < NK; k++) begin
                        got  = psum_t'(o_psum[k*PSUM_WIDTH +: PSUM_WIDTH]);
                        want = ref_sum(exp_line, exp_pos, k);
                        if (got !== want) begin
                            $display("CHECK FAILED at %0t: kernel %0d line %0d pos %0d got %0d exp %0d",
                                     $time, k, exp_line, exp_pos, got, want);
                            err_value++;
                        end
                    end
                    last_pos = (exp_pos == cfg_len - KS);
                    if (o_psum_end !== last_pos) begin
                        $display("CHECK FAILED at %0t: line %0d pos %0d end marker %0b exp %0b",
                                 $time, exp_line, exp_pos, o_psum_end, last_pos);
                        err_value++;
                    end
                    if (last_pos) begin
                        exp_line  = exp_line + 1;
                        exp_pos   = 0;
                        end_cycle = cycle;
                    end else begin
                        exp_pos = exp_pos + 1;
                    end
                end
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    //////////////////////////////
    // Stimulus tasks
    //////////////////////////////

    task automatic start_run(input int len, input int lines);
        @(negedge clk);
        cfg_len     = len;
        cfg_lines   = lines;
        i_line_len  = line_len_t'(len);
        i_num_lines = line_cnt_t'(lines);
        i_start     = 1'b1;
        @(negedge clk);
        i_start    = 1'b0;
        exp_line   = 0;
        exp_pos    = 0;
        run_active = 1'b1;
        if (o_done) begin
            $display("Error at %0t: done still high after start", $time);
            err_proto++;
        end
    endtask

    task automatic load_weights(input int mode);
        logic [NK*NC*BIT_WIDTH-1:0] beat;
        int b;
        int extra;
        b     = 0;
        extra = 0;
        for (int t = 0; t < KS; t++) begin
            for (int k = 0; k < NK; k++) begin
                for (int c = 0; c < NC; c++) begin
                    wt[t][k][c] = pick_value(mode);
                end
            end
        end
        while (b < KS) begin
            if (o_weight_req) begin
                for (int k = 0; k < NK; k++) begin
                    for (int c = 0; c < NC; c++) begin
                        beat[(k*NC+c)*BIT_WIDTH +: BIT_WIDTH] = wt[b][k][c];
                    end
                end
                i_weight     = beat;
                i_weight_vld = 1'b1;
                b++;
            end else begin
                i_weight_vld = 1'b0;
            end
            @(negedge clk);
        end
        // Filler beat stays offered and must never be taken
        i_weight = '1;
        while (!o_data_req) begin
            if (o_weight_req) begin
                extra++;
            end
            @(negedge clk);
        end
        i_weight_vld = 1'b0;
        if (extra != 0) begin
            $display("Error at %0t: %0d weight beats taken past the store size", $time, extra);
            err_proto++;
        end
    endtask

    task automatic feed_lines(input int len, input int lines, input bit gaps, input int mode);
        logic [NC*BIT_WIDTH-1:0] pixel;
        int l;
        int p;
        for (int li = 0; li < lines; li++) begin
            for (int pi = 0; pi < len; pi++) begin
                for (int c = 0; c < NC; c++) begin
                    pix[li][pi][c] = pick_value(mode);
                end
            end
        end
        l = 0;
        p = 0;
        while (l < lines) begin
            if (o_data_req && !(gaps && ($random(seed) & 3) == 0)) begin
                for (int c = 0; c < NC; c++) begin
                    pixel[c*BIT_WIDTH +: BIT_WIDTH] = pix[l][p][c];
                end
                i_data     = pixel;
                i_data_vld = 1'b1;
                if (p == len - 1) begin
                    p = 0;
                    l++;
                end else begin
                    p++;
                end
            end else begin
                i_data_vld = 1'b0;
            end
            @(negedge clk);
        end
        i_data_vld = 1'b0;
    endtask

    task automatic wait_done();
        while (!o_done) begin
            @(negedge clk);
        end
        if (exp_line != cfg_lines) begin
            $display("Error at %0t: done with %0d of %0d lines seen", $time, exp_line, cfg_lines);
            err_proto++;
        end
        if (cycle - end_cycle != 1) begin
            $display("Error at %0t: done came %0d cycles after the last end marker",
                     $time, cycle - end_cycle);
            err_proto++;
        end
        repeat (6) begin
            @(negedge clk);
            if (!o_done) begin
                $display("Error at %0t: done dropped before the next start", $time);
                err_proto++;
            end
        end
        run_active = 1'b0;
    endtask

    task automatic run_test(input int len, input int lines, input bit gaps, input int mode);
        start_run(len, lines);
        load_weights(mode);
        feed_lines(len, lines, gaps, mode);
        wait_done();
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        rst          = 1'b1;
        i_start      = 1'b0;
        i_line_len   = '0;
        i_num_lines  = '0;
        i_weight     = '0;
        i_weight_vld = 1'b0;
        i_data       = '0;
        i_data_vld   = 1'b0;
        err_value    = 0;
        err_proto    = 0;
        run_active   = 1'b0;
        end_cycle    = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (o_weight_req || o_data_req || o_psum_vld || o_psum_end || o_done) begin
            $display("Error at %0t: outputs not idle after reset", $time);
            err_proto++;
        end

        run_test(12, 1, 1'b0, 0);
        run_test(16, 4, 1'b1, 0);
        run_test(10, 2, 1'b1, 1);
        // Restart straight from the finished state
        run_test(7, 3, 1'b1, 0);

        $display("Errors: %0d value, %0d protocol", err_value, err_proto);
        if (err_value + err_proto == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
common/line_conv_pkg.sv
source/act_window.sv
source/weight_store.sv
kcpe_array/kernel_channel_pe.sv
kcpe_array/kcpe_array.sv
source/line_ctrl.sv
source/line_conv_engine.sv
testbench/line_conv_engine_tb.sv
